// File: common/road_pkg.sv
`default_nettype none

package road_pkg;

	// One matrix row, MSB is the leftmost LED
	typedef logic [7:0] row_t;
	// Row 0 is the top of the matrix
	typedef row_t frame_t [8];
	typedef logic [2:0] level_t;
	typedef logic [4:0] progress_t;
	typedef logic [3:0] max_addr_t;
	// Upper byte address, lower byte data
	typedef logic [15:0] max_word_t;

	typedef enum logic [1:0] {
		st_idle,
		st_play,
		st_over
	} game_state_t;

	// ----------------------------------------------------------------------
	// Game constants
	// ----------------------------------------------------------------------
	localparam int NUM_LEVELS     = 8;
	localparam int PROGRESS_STEPS = 32;

	// Car shape shown while idle
	localparam frame_t CAR_PICTURE = '{
		8'b00010000,
		8'b00000000,
		8'b00010000,
		8'b00111000,
		8'b01111100,
		8'b01111100,
		8'b00111000,
		8'b00010000
	};

	// Road edges with a few obstacles in between
	localparam row_t ROAD_PATTERN [8] = '{
		8'b10000001,
		8'b10010001,
		8'b10000001,
		8'b10000101,
		8'b10000001,
		8'b10100001,
		8'b10000001,
		8'b11000011
	};

	// ----------------------------------------------------------------------
	// MAX7219 registers
	// ----------------------------------------------------------------------
	localparam logic [3:0] DISPLAY_INTENSITY = 4'hA;

	localparam max_addr_t ADDR_DIGIT0     = 4'h1;
	localparam max_addr_t ADDR_DECODE     = 4'h9;
	localparam max_addr_t ADDR_INTENSITY  = 4'hA;
	localparam max_addr_t ADDR_SCAN_LIMIT = 4'hB;
	localparam max_addr_t ADDR_SHUTDOWN   = 4'hC;
	localparam max_addr_t ADDR_TEST       = 4'hF;

	// New top row: pattern picked by progress, rotated left by level
	function automatic row_t next_road_row(level_t level, progress_t progress);
		logic [15:0] doubled;
		doubled = {ROAD_PATTERN[progress[2:0]], ROAD_PATTERN[progress[2:0]]} << level;
		return doubled[15:8];
	endfunction

endpackage

`default_nettype wire

// File: hw/button_debounce.sv
`default_nettype none

module button_debounce #(
	parameter int DEBOUNCE_CYCLES = 500_000
) (
	input  logic clock_50,
	input  logic reset,
	input  logic button_n,
	output logic press
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	// Two-flop synchronizer, idles high like the pin
	logic [1:0] sync;
	// Accepted level, high while pressed
	logic pressed;
	logic pressed_q;
	// Run of samples that differ from the accepted level
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clock_50) begin
		if (reset) begin
			sync      <= 2'b11;
			pressed   <= 1'b0;
			pressed_q <= 1'b0;
			cnt       <= '0;
			press     <= 1'b0;
		end else begin
			sync      <= {sync[0], button_n};
			pressed_q <= pressed;
			// One pulse per accepted press, none on release
			press     <= pressed & ~pressed_q;
			if (~sync[1] == pressed) begin
				// Glitch ended early, start over
				cnt <= '0;
			end else if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
				pressed <= ~sync[1];
				cnt     <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: game/game_control.sv
`default_nettype none

module game_control import road_pkg::*; (
	input  logic        clock_50,
	input  logic        reset,
	input  logic        start,
	input  logic        step,
	output game_state_t state,
	output level_t      level,
	output progress_t   progress
);

	game_state_t state_next;
	// Step that closes the current level
	logic        wrap;
	// Step that closes the last level
	logic        last_step;

	assign wrap      = step && (progress == progress_t'(PROGRESS_STEPS - 1));
	assign last_step = wrap && (level == level_t'(NUM_LEVELS - 1));

	// ----------------------------------------------------------------------
	// Game FSM
	// ----------------------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (start) begin
					state_next = st_play;
				end
			end
			st_play: begin
				// Start button ignored during a game
				if (last_step) begin
					state_next = st_over;
				end
			end
			st_over: begin
				if (start) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clock_50) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// ----------------------------------------------------------------------
	// Level and progress counters
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_50) begin
		if (reset) begin
			level    <= '0;
			progress <= '0;
		end else if (state == st_idle && start) begin
			// Fresh game
			level    <= '0;
			progress <= '0;
		end else if (state == st_play && step) begin
			if (wrap) begin
				progress <= '0;
				// Level holds at the top once the game ends
				if (!last_step) begin
					level <= level + 1'b1;
				end
			end else begin
				progress <= progress + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/step_timer.sv
`default_nettype none

module step_timer import road_pkg::*; #(
	parameter int STEP_CYCLES = 12_500_000
) (
	input  logic        clock_50,
	input  logic        reset,
	input  game_state_t state,
	input  level_t      level,
	output logic        step
);

	localparam int STEP_W = $clog2(STEP_CYCLES + 1);
	// Period cut per level
	localparam int LEVEL_DEC = STEP_CYCLES / 16;

	logic [STEP_W-1:0] cnt;
	logic [STEP_W-1:0] limit;

	// Faster steps on higher levels
	assign limit = STEP_W'(STEP_CYCLES) - STEP_W'(level) * STEP_W'(LEVEL_DEC);

	always_ff @(posedge clock_50) begin
		if (reset || state != st_play) begin
			cnt  <= '0;
			step <= 1'b0;
		end else if (cnt == limit - 1'b1) begin
			cnt  <= '0;
			step <= 1'b1;
		end else begin
			cnt  <= cnt + 1'b1;
			step <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: road/road_scroller.sv
`default_nettype none

module road_scroller import road_pkg::*; (
	input  logic        clock_50,
	input  logic        reset,
	input  game_state_t state,
	input  logic        step,
	input  level_t      level,
	input  progress_t   progress,
	output frame_t      frame
);

	// Row entering at the top on the next step
	row_t new_row;

	// Level and progress still hold their pre-step values here
	assign new_row = next_road_row(level, progress);

	// ----------------------------------------------------------------------
	// Row shift register
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_50) begin
		if (reset || state == st_idle) begin
			// Blank road ready for the next game
			for (int i = 0; i < 8; i++) begin
				frame[i] <= '0;
			end
		end else if (state == st_play && step) begin
			frame[0] <= new_row;
			// Everything moves one row down, bottom row drops out
			for (int i = 1; i < 8; i++) begin
				frame[i] <= frame[i-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: max7219/max7219_driver.sv
`default_nettype none

module max7219_driver import road_pkg::*; (
	input  logic   clock_50,
	input  logic   reset,
	input  frame_t frame,
	output logic   max7219_din,
	output logic   max7219_ncs,
	output logic   max7219_clk
);

	// 1 load, 32 half periods of clk, 3 more with ncs high
	localparam int WORD_CYCLES = 36;
	// Cycle where ncs rises and latches the word
	localparam int SHIFT_END   = 32;

	typedef enum logic {
		ph_setup,
		ph_scan
	} phase_t;

	phase_t    phase;
	logic [2:0] setup_idx;
	// Column on screen, digit address minus one
	logic [2:0] col;
	logic [7:0] col_data;
	max_word_t  word;
	max_word_t  shreg;
	logic [5:0] cyc;

	// ----------------------------------------------------------------------
	// Word select
	// ----------------------------------------------------------------------
	always_comb begin
		// Column c is bit 7-c of each row, row 0 lands on data bit 7
		col_data = '0;
		for (int r = 0; r < 8; r++) begin
			col_data[7-r] = frame[r][3'd7 - col];
		end
		if (phase == ph_setup) begin
			case (setup_idx)
				3'd0:    word = {4'h0, ADDR_DECODE, 8'h00};
				3'd1:    word = {4'h0, ADDR_INTENSITY, 4'h0, DISPLAY_INTENSITY};
				3'd2:    word = {4'h0, ADDR_SCAN_LIMIT, 8'h07};
				3'd3:    word = {4'h0, ADDR_SHUTDOWN, 8'h01};
				default: word = {4'h0, ADDR_TEST, 8'h00};
			endcase
		end else begin
			word = {4'h0, ADDR_DIGIT0 + max_addr_t'(col), col_data};
		end
	end

	// Sequencer steps once per word, at the load
	always_ff @(posedge clock_50) begin
		if (reset) begin
			phase     <= ph_setup;
			setup_idx <= '0;
			col       <= '0;
		end else if (cyc == '0) begin
			if (phase == ph_setup) begin
				if (setup_idx == 3'd4) begin
					phase <= ph_scan;
				end else begin
					setup_idx <= setup_idx + 1'b1;
				end
			end else begin
				// Digits 1 to 8 forever
				col <= col + 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Serial shifter
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_50) begin
		if (reset) begin
			cyc         <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
			max7219_din <= 1'b0;
		end else begin
			cyc <= (cyc == 6'(WORD_CYCLES - 1)) ? '0 : cyc + 1'b1;
			if (cyc == '0) begin
				// MSB out first
				max7219_ncs <= 1'b0;
				max7219_clk <= 1'b0;
				max7219_din <= word[15];
			end else if (cyc < 6'(SHIFT_END)) begin
				if (cyc[0]) begin
					// Receiver samples here
					max7219_clk <= 1'b1;
				end else begin
					// din only moves with clk low
					max7219_clk <= 1'b0;
					max7219_din <= shreg[14];
				end
			end else if (cyc == 6'(SHIFT_END)) begin
				max7219_ncs <= 1'b1;
				max7219_clk <= 1'b0;
				max7219_din <= 1'b0;
			end
		end
	end

	// Frame column captured once, at the start of the word
	always_ff @(posedge clock_50) begin
		if (cyc == '0) begin
			shreg <= word;
		end else if (cyc < 6'(SHIFT_END) && !cyc[0]) begin
			shreg <= shreg << 1;
		end
	end

endmodule

`default_nettype wire

// File: hw/road_game_top.sv
`default_nettype none

module road_game_top import road_pkg::*; #(
	// STEP_CYCLES/2 must exceed two full refreshes (2 x 288 cycles)
	parameter int DEBOUNCE_CYCLES = 500_000,
	parameter int STEP_CYCLES     = 12_500_000
) (
	input  logic clock_50,
	input  logic reset,
	input  logic start_button_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	logic        start_pulse;
	logic        step_pulse;
	game_state_t state;
	level_t      level;
	progress_t   progress;
	frame_t      road_frame;
	frame_t      disp_frame;

	// ----------------------------------------------------------------------
	// Input and game logic
	// ----------------------------------------------------------------------
	button_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_start_debounce (
		.clock_50(clock_50),
		.reset(reset),
		.button_n(start_button_n),
		.press(start_pulse)
	);

	game_control u_game_control (
		.clock_50(clock_50),
		.reset(reset),
		.start(start_pulse),
		.step(step_pulse),
		.state(state),
		.level(level),
		.progress(progress)
	);

	step_timer #(
		.STEP_CYCLES(STEP_CYCLES)
	) u_step_timer (
		.clock_50(clock_50),
		.reset(reset),
		.state(state),
		.level(level),
		.step(step_pulse)
	);

	road_scroller u_road_scroller (
		.clock_50(clock_50),
		.reset(reset),
		.state(state),
		.step(step_pulse),
		.level(level),
		.progress(progress),
		.frame(road_frame)
	);

	// ----------------------------------------------------------------------
	// Display
	// ----------------------------------------------------------------------
	// Car picture while idle, road in play and frozen road after game over
	always_comb begin
		if (state == st_idle) begin
			disp_frame = CAR_PICTURE;
		end else begin
			disp_frame = road_frame;
		end
	end

	max7219_driver u_max7219_driver (
		.clock_50(clock_50),
		.reset(reset),
		.frame(disp_frame),
		.max7219_din(max7219_din),
		.max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk)
	);

endmodule

`default_nettype wire

// File: verif/tb_road_game.sv
`default_nettype none

module tb_road_game import road_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD      = 40;
	localparam int DEBOUNCE_CYCLES = 8;
	// Top level period 1280 - 7*80 = 720, still above two refreshes
	localparam int STEP_CYCLES     = 1280;
	localparam int REFRESH_CYCLES  = 288;
	localparam int TOTAL_STEPS     = NUM_LEVELS * PROGRESS_STEPS;
	localparam int SEED            = 32'h9012_de30;

	localparam int N_IDLE_GLITCHES = 8;
	localparam int N_PLAY_PRESSES  = 30;
	localparam int N_END_GLITCHES  = 6;
	localparam int MAX_LOW         = DEBOUNCE_CYCLES + 20;
	localparam int MIN_GAP         = DEBOUNCE_CYCLES + 5;
	localparam int MAX_GAP         = DEBOUNCE_CYCLES + 30;
	localparam longint N_PRESSES   = N_IDLE_GLITCHES + N_PLAY_PRESSES + N_END_GLITCHES + 2;
	localparam longint WATCHDOG_CYCLES = 8 + N_PRESSES * (MAX_LOW + MAX_GAP)
		+ longint'(TOTAL_STEPS) * STEP_CYCLES + 2 * STEP_CYCLES
		+ 20 * REFRESH_CYCLES + 20000;

	// What the display should show right now
	localparam int MODE_CAR  = 0;
	localparam int MODE_ROAD = 1;

	localparam max_word_t SETUP_WORDS [5] = '{
		{4'h0, ADDR_DECODE, 8'h00},
		{4'h0, ADDR_INTENSITY, 4'h0, DISPLAY_INTENSITY},
		{4'h0, ADDR_SCAN_LIMIT, 8'h07},
		{4'h0, ADDR_SHUTDOWN, 8'h01},
		{4'h0, ADDR_TEST, 8'h00}
	};

	logic clock_50;
	logic reset;
	logic start_button_n;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;

	// Road frame after each step, index 0 is the blank road
	frame_t    exp_frames [TOTAL_STEPS + 1];
	row_t      col_bytes [8];
	max_word_t shift_word;
	int        bit_count;
	int        word_count;
	int        refresh_count;
	int        mode;
	int        shown_step;
	// Accepted press under way, display may switch
	bit        pending;

	road_game_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.STEP_CYCLES(STEP_CYCLES)
	) DUT (
		.clock_50(clock_50),
		.reset(reset),
		.start_button_n(start_button_n),
		.max7219_din(max7219_din),
		.max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk)
	);

	initial begin
		clock_50 = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clock_50 = ~clock_50;
		end
	end

	// ----------------------------------------------------------------------
	// Compare tasks and helpers
	// ----------------------------------------------------------------------
	task automatic end_with_failure();
		$display("Regression failed");
		$fatal(1, "check failed");
	endtask

	task automatic check_word(string name, max_word_t got, max_word_t expected);
		if (got !== expected) begin
			$display("Error: %s got %h expected %h", name, got, expected);
			end_with_failure();
		end
	endtask

	task automatic check_frame(string name, frame_t got, frame_t expected);
		for (int r = 0; r < 8; r++) begin
			if (got[r] !== expected[r]) begin
				$display("Error: %s row %0d got %h expected %h", name, r, got[r], expected[r]);
				end_with_failure();
			end
		end
	endtask

	function automatic row_t rotate_left(row_t value, int amount);
		row_t result;
		// Bits leaving the MSB come back in at the LSB
		result = (value << amount) | (value >> (8 - amount));
		return result;
	endfunction

	// Every road state of a full game
	task automatic build_model();
		int lvl;
		for (int r = 0; r < 8; r++) begin
			exp_frames[0][r] = '0;
		end
		for (int n = 0; n < TOTAL_STEPS; n++) begin
			lvl = n / PROGRESS_STEPS;
			// Pattern index is progress mod 8
			exp_frames[n+1][0] = rotate_left(ROAD_PATTERN[n % 8], lvl);
			for (int r = 1; r < 8; r++) begin
				exp_frames[n+1][r] = exp_frames[n][r-1];
			end
		end
	endtask

	// Largest column split with columns below it from cur and the rest from nxt
	function automatic int splice_point(frame_t shown, frame_t cur, frame_t nxt);
		int found;
		bit match;
		found = -1;
		for (int j = 8; j >= 0 && found < 0; j--) begin
			match = 1'b1;
			for (int r = 0; r < 8; r++) begin
				for (int c = 0; c < 8; c++) begin
					if (shown[r][7-c] !== (c < j ? cur[r][7-c] : nxt[r][7-c])) begin
						match = 1'b0;
					end
				end
			end
			if (match) begin
				found = j;
			end
		end
		return found;
	endfunction

	// ----------------------------------------------------------------------
	// Refresh checker
	// ----------------------------------------------------------------------
	task automatic judge_refresh();
		frame_t shown;
		frame_t cur;
		frame_t nxt;
		bit     has_nxt;
		int     cut;
		// Digit data bit 7 is row 0
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				shown[r][7-c] = col_bytes[c][7-r];
			end
		end
		if (mode == MODE_CAR) begin
			cur     = CAR_PICTURE;
			nxt     = exp_frames[0];
			has_nxt = pending;
		end else begin
			cur = exp_frames[shown_step];
			if (shown_step < TOTAL_STEPS) begin
				nxt     = exp_frames[shown_step + 1];
				has_nxt = 1'b1;
			end else begin
				// Frozen road until the next press
				nxt     = CAR_PICTURE;
				has_nxt = pending;
			end
		end
		cut = splice_point(shown, cur, nxt);
		if (has_nxt && cut >= 0 && cut < 8) begin
			// Moved on by exactly one state
			if (mode == MODE_CAR) begin
				mode       = MODE_ROAD;
				shown_step = 0;
				pending    = 1'b0;
			end else if (shown_step < TOTAL_STEPS) begin
				shown_step++;
			end else begin
				mode    = MODE_CAR;
				pending = 1'b0;
			end
		end else begin
			check_frame("decoded frame", shown, cur);
		end
		refresh_count++;
	endtask

	task automatic take_word();
		int digit;
		if (bit_count != 16) begin
			$display("Serial word ended after %0d clock pulses instead of 16", bit_count);
			end_with_failure();
		end
		if (word_count < 5) begin
			check_word("setup word", shift_word, SETUP_WORDS[word_count]);
		end else begin
			// Digits 1 to 8 in a loop
			digit = (word_count - 5) % 8 + 1;
			check_word("digit address", {shift_word[15:8], 8'h00},
				{4'h0, max_addr_t'(digit), 8'h00});
			col_bytes[digit-1] = shift_word[7:0];
			if (digit == 8) begin
				judge_refresh();
			end
		end
		word_count++;
		bit_count = 0;
	endtask

	// Serial decoder, receiver samples on rising clk
	always @(posedge max7219_clk) begin
		if (!max7219_ncs) begin
			shift_word = {shift_word[14:0], max7219_din};
			bit_count++;
		end
	end

	// ncs rising latches the word
	always @(posedge max7219_ncs) begin
		if (!reset) begin
			take_word();
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	task automatic push_button(int low_cycles, int gap_cycles);
		@(posedge clock_50);
		#5;
		start_button_n = 1'b0;
		repeat (low_cycles) @(posedge clock_50);
		#5;
		start_button_n = 1'b1;
		repeat (gap_cycles) @(posedge clock_50);
	endtask

	task automatic glitch_button();
		push_button($urandom_range(DEBOUNCE_CYCLES - 1, 1), $urandom_range(MAX_GAP, MIN_GAP));
	endtask

	task automatic hold_button();
		push_button($urandom_range(MAX_LOW, DEBOUNCE_CYCLES + 5),
			$urandom_range(MAX_GAP, MIN_GAP));
	endtask

	task automatic wait_refreshes(int count);
		int target;
		target = refresh_count + count;
		wait (refresh_count >= target);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the game sequence finished");
		end_with_failure();
	end

	initial begin
		int unsigned seed_init;
		int          target;
		reset          = 1'b1;
		start_button_n = 1'b1;
		pending        = 1'b0;
		mode           = MODE_CAR;
		shown_step     = 0;
		word_count     = 0;
		bit_count      = 0;
		refresh_count  = 0;
		shift_word     = '0;
		seed_init      = $urandom(SEED);
		build_model();
		repeat (8) @(posedge clock_50);
		#5;
		reset = 1'b0;

		// Idle with short glitches only
		wait_refreshes(2);
		repeat (N_IDLE_GLITCHES) begin
			glitch_button();
		end
		wait_refreshes(2);

		// Held press starts the game
		pending = 1'b1;
		hold_button();
		wait (mode == MODE_ROAD);

		// Start button has no effect in play
		repeat (N_PLAY_PRESSES) begin
			push_button($urandom_range(MAX_LOW, 1), $urandom_range(MAX_GAP, MIN_GAP));
		end

		// Last level done, road must freeze
		wait (shown_step == TOTAL_STEPS);
		target = refresh_count + 4;
		repeat (2 * STEP_CYCLES) @(posedge clock_50);
		if (refresh_count < target) begin
			$display("Display stopped refreshing after the game ended");
			end_with_failure();
		end

		// Back to the car picture
		pending = 1'b1;
		hold_button();
		wait (mode == MODE_CAR);
		wait_refreshes(2);
		repeat (N_END_GLITCHES) begin
			glitch_button();
		end
		wait_refreshes(2);

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
common/road_pkg.sv
hw/button_debounce.sv
game/game_control.sv
hw/step_timer.sv
road/road_scroller.sv
max7219/max7219_driver.sv
hw/road_game_top.sv
verif/tb_road_game.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the road game testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_road_game \
	-f verilog.f -o tb_road_game_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_road_game_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
	echo "No result found in $LOG"
	exit 1
fi
exit 0
